//--- compile.f
+incdir+rtl
rtl/fas_pkg.sv
rtl/fir_tap_line.sv
rtl/fir_mac.sv
rtl/frame_collector.sv
rtl/fas_top.sv
dv/fas_tb.sv

//--- Bender.yml
package:
  name: fas

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fas_pkg.sv
      - rtl/fir_tap_line.sv
      - rtl/fir_mac.sv
      - rtl/frame_collector.sv
      - rtl/fas_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/fas_tb.sv

//--- dv/fas_tb.sv
// Frequency analyzer front end testbench
// Drives table rows of sample runs and gaps into the FIR and framer,
// predicts every filter output and frame, and checks them cycle by cycle

`timescale 1ns/1ps

`include "fas_macros.svh"

module fas_tb;

  import fas_pkg::*;

  localparam int n_rows = 9;

  // Pattern kinds used in the stimulus table
  localparam int k_impulse = 0;
  localparam int k_const   = 1;
  localparam int k_alt     = 2;
  localparam int k_random  = 3;

  logic    clk = 1'b0;
  logic    rst;
  logic    data_valid;
  sample_t data;
  sample_t fir_d;
  logic    fir_valid;
  frame_t  frame;
  logic    frame_valid;

  int          edge_n = 0;      // Rising edges seen so far
  int          cyc_limit = 0;   // Timeout, set once the table is loaded
  logic [31:0] rng = 32'h4a12;  // xorshift state

  // Stimulus table, one row per run
  int      row_kind [n_rows];
  int      row_run  [n_rows];
  int      row_gap  [n_rows];
  sample_t row_amp  [n_rows];

  // Reference model state
  sample_t model_taps [`FAS_TAPS];  // Index 0 newest
  int      model_run;
  int      last_due = -10;           // Due cycle of the previous output
  int      frame_fill;
  frame_t  frame_acc;

  // Expected results with the edge count at which each must show
  sample_t exp_d_q[$];
  int      exp_d_due[$];
  frame_t  exp_f_q[$];
  int      exp_f_due[$];

  fas_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .data_valid  (data_valid),
    .data        (data),
    .fir_d       (fir_d),
    .fir_valid   (fir_valid),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  always #20 clk = ~clk;  // 40 ns period

  always @(posedge clk) edge_n <= edge_n + 1;

  //////////////////////////////
  // Failure reporting and checks
  //////////////////////////////
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "Stopping on first error");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at %0t ns: %s got %b expected %b",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at %0t ns: %s got %h expected %h",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_frame(input frame_t got, input frame_t exp);
    for (int s = 0; s < `FAS_FRAME_LEN; s++) begin
      check_sample($sformatf("frame[%0d]", s), got[s], exp[s]);
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Sum of products, drop fraction, nudge negatives up, wrap to 16 bits
  function automatic sample_t filter_out();
    longint acc;
    longint shr;
    acc = 0;
    for (int k = 0; k < `FAS_TAPS; k++) begin
      acc = acc + longint'(model_taps[k]) * longint'(fir_coef[k]);
    end
    shr = acc >>> `FAS_COEF_FRAC;
    if (acc < 0) shr = shr + 1;
    return shr[`FAS_SAMPLE_W-1:0];
  endfunction

  // Called on the falling edge that drives an accepted sample
  task automatic model_accept(input sample_t s);
    sample_t y;
    int      due;
    for (int k = `FAS_TAPS - 1; k > 0; k--) model_taps[k] = model_taps[k-1];
    model_taps[0] = s;
    if (model_run < `FAS_TAPS) model_run++;
    if (model_run == `FAS_TAPS) begin
      y   = filter_out();
      due = edge_n + 2;               // Accept edge, then output register
      exp_d_q.push_back(y);
      exp_d_due.push_back(due);
      if (due != last_due + 1) frame_fill = 0;  // fir_valid gap restarts frame
      frame_acc[frame_fill] = y;
      frame_fill++;
      if (frame_fill == `FAS_FRAME_LEN) begin
        exp_f_q.push_back(frame_acc);
        exp_f_due.push_back(due + 1);
        frame_fill = 0;
      end
      last_due = due;
    end
  endtask

  //////////////////////////////
  // Output monitor
  //////////////////////////////
  // Outputs settle after the rising edge, so read them on the falling one
  always @(negedge clk) begin
    logic exp_fv;
    logic exp_frv;
    if (rst === 1'b0) begin
      exp_fv  = (exp_d_due.size() > 0) && (exp_d_due[0] == edge_n);
      exp_frv = (exp_f_due.size() > 0) && (exp_f_due[0] == edge_n);
      check_flag("fir_valid", fir_valid, exp_fv);
      check_flag("frame_valid", frame_valid, exp_frv);
      if (exp_fv) begin
        check_sample("fir_d", fir_d, exp_d_q.pop_front());
        void'(exp_d_due.pop_front());
      end
      if (exp_frv) begin
        check_frame(frame, exp_f_q.pop_front());
        void'(exp_f_due.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    if (cyc_limit > 0 && edge_n >= cyc_limit) begin
      report_failure($sformatf("Timeout after %0d cycles with outputs still pending",
                               edge_n));
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  task automatic set_row(input int idx, input int kind, input int run, input int gap,
                         input sample_t amp);
    row_kind[idx] = kind;
    row_run[idx]  = run;
    row_gap[idx]  = gap;
    row_amp[idx]  = amp;
  endtask

  task automatic load_table();
    set_row(0, k_impulse, 64, 2, 16'sd1);      // Unit impulse, coefficients round away
    set_row(1, k_impulse, 64, 2, 16'sh4000);   // Scaled impulse walks the table out
    set_row(2, k_const,   48, 1, 16'sd12000);  // DC gain
    set_row(3, k_alt,     40, 2, 16'sd0);      // Full-scale Nyquist tone
    set_row(4, k_random,  70, 3, 16'sd0);
    set_row(5, k_random,  20, 1, 16'sd0);      // Short run, no output expected
    set_row(6, k_random,  52, 2, 16'sd0);      // One frame plus an abandoned partial
    set_row(7, k_const,   63, 4, 16'sh8000);   // Most negative constant, two frames
    set_row(8, k_alt,     47, 2, 16'sd0);      // Exactly one frame
  endtask

  task automatic apply_row(input int idx);
    sample_t s;
    for (int i = 0; i < row_run[idx]; i++) begin
      @(negedge clk);
      case (row_kind[idx])
        k_impulse: s = (i == `FAS_TAPS - 1) ? row_amp[idx] : '0;
        k_const:   s = row_amp[idx];
        k_alt:     s = i[0] ? 16'sh8000 : 16'sh7fff;
        default: begin
          rng = next_rand(rng);
          s   = rng[15:0];
        end
      endcase
      data_valid = 1'b1;
      data       = s;
      model_accept(s);
    end
    for (int g = 0; g < row_gap[idx]; g++) begin
      @(negedge clk);
      data_valid = 1'b0;
      data       = 16'h5a5a ^ sample_t'(g);  // Must be ignored
      model_run  = 0;                        // Taps stay, run restarts
    end
  endtask

  initial begin
    int total;
    int drain;
    rst        = 1'b1;
    data_valid = 1'b0;
    data       = '0;
    model_run  = 0;
    frame_fill = 0;
    frame_acc  = '0;
    for (int k = 0; k < `FAS_TAPS; k++) model_taps[k] = '0;
    load_table();
    total = 0;
    for (int r = 0; r < n_rows; r++) total += row_run[r] + row_gap[r];
    cyc_limit = 2 * total + 100;

    repeat (16) @(negedge clk);
    rst = 1'b0;

    // Idle after reset, all outputs at zero
    repeat (4) begin
      @(negedge clk);
      check_sample("fir_d", fir_d, '0);
      check_frame(frame, '0);
    end

    for (int r = 0; r < n_rows; r++) apply_row(r);

    @(negedge clk);
    data_valid = 1'b0;
    drain = 0;
    while ((exp_d_q.size() > 0 || exp_f_q.size() > 0) && drain < 50) begin
      @(negedge clk);
      drain++;
    end
    repeat (4) @(negedge clk);  // Nothing further may appear

    if (exp_d_q.size() > 0 || exp_f_q.size() > 0) begin
      report_failure("Expected filter outputs or frames never appeared");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

//--- rtl/fas_top.sv
// Frequency analyzer front end
// Input stream through the 32-tap low-pass FIR into 16-sample frames

`timescale 1ns/1ps

module fas_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             data_valid,
  input  fas_pkg::sample_t data,
  output fas_pkg::sample_t fir_d,        // Filtered sample
  output logic             fir_valid,
  output fas_pkg::frame_t  frame,        // Last 16 outputs, oldest first
  output logic             frame_valid
);

  fas_pkg::tap_vec_t taps;          // Delay line contents
  logic              window_fresh;  // Taps hold a full run window

  //////////////////////////////
  // FIR stage
  //////////////////////////////
  fir_tap_line u_tap_line (
    .clk          (clk),
    .rst          (rst),
    .data_valid   (data_valid),
    .data         (data),
    .taps         (taps),
    .window_fresh (window_fresh)
  );

  // Registers the filter result one cycle after the window is flagged
  fir_mac u_mac (
    .clk          (clk),
    .rst          (rst),
    .taps         (taps),
    .window_fresh (window_fresh),
    .fir_d        (fir_d),
    .fir_valid    (fir_valid)
  );

  //////////////////////////////
  // Framing
  //////////////////////////////
  frame_collector u_frame (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

endmodule

//--- rtl/frame_collector.sv
// Serial to parallel frame collector
// Writes 16 back-to-back filter outputs into a frame, oldest in slot 0,
// and pulses frame_valid the cycle after the last slot is filled

`timescale 1ns/1ps

`include "fas_macros.svh"

module frame_collector (
  input  logic             clk,
  input  logic             rst,
  input  logic             fir_valid,
  input  fas_pkg::sample_t fir_d,
  output fas_pkg::frame_t  frame,
  output logic             frame_valid  // Single-cycle frame done strobe
);

  import fas_pkg::*;

  localparam int slot_w = $clog2(`FAS_FRAME_LEN);
  localparam logic [slot_w-1:0] slot_last = slot_w'(`FAS_FRAME_LEN - 1);

  logic [slot_w-1:0] slot;      // Next slot to write
  logic              slot_end;  // Current write closes the frame

  assign slot_end = (slot == slot_last);

  //////////////////////////////
  // Slot index and done strobe
  //////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      slot        <= '0;
      frame_valid <= 1'b0;
    end else if (fir_valid) begin
      slot        <= slot_end ? '0 : slot + 1'b1;
      frame_valid <= slot_end;
    end else begin
      slot        <= '0;    // Partial frame dropped on a gap
      frame_valid <= 1'b0;
    end
  end

  //////////////////////////////
  // Frame register bank
  //////////////////////////////
  // Slots of an abandoned frame are simply overwritten by the next one
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      frame <= '0;
    end else if (fir_valid) begin
      frame[slot] <= fir_d;
    end
  end

endmodule

//--- rtl/fir_mac.sv
// FIR multiply-accumulate
// Sums all tap products with the package coefficients, drops the
// fraction bits with a nudge toward zero for negative sums and
// registers the 16-bit result with its valid flag

`timescale 1ns/1ps

`include "fas_macros.svh"

module fir_mac (
  input  logic              clk,
  input  logic              rst,
  input  fas_pkg::tap_vec_t taps,
  input  logic              window_fresh,  // Taps hold a complete window
  output fas_pkg::sample_t  fir_d,         // Holds between updates
  output logic              fir_valid
);

  import fas_pkg::*;

  acc_t    acc;      // Full precision sum
  acc_t    acc_shr;  // Integer part after dropping the fraction
  acc_t    acc_rnd;  // Negative sums pushed up by one
  sample_t fir_nxt;  // Wrapped to output width

  //////////////////////////////
  // Product sum
  //////////////////////////////
  // Operands sign-extend to accumulator width before the multiply
  always_comb begin
    acc = '0;
    for (int k = 0; k < `FAS_TAPS; k++) begin
      acc = acc + $signed(taps[k]) * fir_coef[k];
    end
  end

  //////////////////////////////
  // Scale and round
  //////////////////////////////
  assign acc_shr = acc >>> `FAS_COEF_FRAC;        // Arithmetic, keeps sign
  assign acc_rnd = acc[`FAS_ACC_W-1] ? acc_shr + 1'b1
                                     : acc_shr;
  assign fir_nxt = acc_rnd[`FAS_SAMPLE_W-1:0];    // Low bits only, wraps

  //////////////////////////////
  // Output register
  //////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fir_d     <= '0;
      fir_valid <= 1'b0;
    end else begin
      fir_valid <= window_fresh;  // Lines up with the captured sample
      if (window_fresh) begin
        fir_d <= fir_nxt;
      end
    end
  end

endmodule

//--- rtl/fir_tap_line.sv
// FIR delay line
// Shifts in each accepted sample and tracks the current unbroken run
// Flags a fresh window once 32 samples of one run are present

`timescale 1ns/1ps

`include "fas_macros.svh"

module fir_tap_line (
  input  logic             clk,
  input  logic             rst,
  input  logic             data_valid,   // Sample strobe, no back-pressure
  input  fas_pkg::sample_t data,
  output fas_pkg::tap_vec_t taps,        // Tap 0 is newest
  output logic             window_fresh  // One cycle per full-window sample
);

  import fas_pkg::*;

  localparam int cnt_w = $clog2(`FAS_TAPS + 1);  // Counts 0..32
  localparam logic [cnt_w-1:0] cnt_full = cnt_w'(`FAS_TAPS);

  logic [cnt_w-1:0] run_cnt;  // Samples in the current run, saturating
  logic             run_full; // Counter already at its limit
  logic             fill_hit; // This sample completes or extends a window

  assign run_full = (run_cnt == cnt_full);
  // Counter at 31 or 32 means this sample leaves it at 32
  assign fill_hit = (run_cnt >= cnt_full - 1'b1);

  //////////////////////////////
  // Delay line
  //////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      taps <= '0;
    end else if (data_valid) begin
      taps <= {taps[`FAS_TAPS-2:0], data};  // Oldest falls off the top
    end
    // Taps hold through a gap, only the run counter restarts
  end

  //////////////////////////////
  // Run counter and strobe
  //////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run_cnt      <= '0;
      window_fresh <= 1'b0;
    end else if (data_valid) begin
      if (!run_full) begin
        run_cnt <= run_cnt + 1'b1;
      end
      window_fresh <= fill_hit;  // 32nd or later sample of the run
    end else begin
      run_cnt      <= '0;        // Gap breaks the run
      window_fresh <= 1'b0;
    end
  end

endmodule

//--- rtl/fas_pkg.sv
// Frequency analyzer front end types
// Sample, coefficient, accumulator and vector types plus the FIR table

`include "fas_macros.svh"

package fas_pkg;

  typedef logic signed [`FAS_SAMPLE_W-1:0] sample_t;  // Stream sample
  typedef logic signed [`FAS_COEF_W-1:0]   coef_t;    // Q3.16 coefficient
  typedef logic signed [`FAS_ACC_W-1:0]    acc_t;     // MAC sum

  // Delay line, index 0 holds the newest sample
  typedef sample_t [`FAS_TAPS-1:0] tap_vec_t;

  // Collected frame, slot 0 holds the oldest output
  typedef sample_t [`FAS_FRAME_LEN-1:0] frame_t;

  //////////////////////////////
  // Low-pass FIR coefficients
  //////////////////////////////
  // Entry k weights tap k, table is symmetric about 15/16
  localparam coef_t fir_coef [0:`FAS_TAPS-1] = '{
    20'hFFF9E,  // -1.495e-3
    20'hFFF86,  // -1.862e-3
    20'hFFFA7,
    20'h0003B,
    20'h0014B,  //  5.051e-3
    20'h0024A,
    20'h00222,
    20'hFFFE4,
    20'hFFBC5,  // -1.653e-2
    20'hFF7CA,
    20'hFF74E,  // -3.397e-2
    20'hFFD74,
    20'h00B1A,
    20'h01DAC,  //  1.159e-1
    20'h02F9E,
    20'h03AA9,  // Peak  2.291e-1
    20'h03AA9,  // Peak, mirror starts here
    20'h02F9E,
    20'h01DAC,
    20'h00B1A,
    20'hFFD74,
    20'hFF74E,
    20'hFF7CA,
    20'hFFBC5,
    20'hFFFE4,
    20'h00222,
    20'h0024A,
    20'h0014B,
    20'h0003B,
    20'hFFFA7,
    20'hFFF86,
    20'hFFF9E
  };

endpackage

//--- rtl/fas_macros.svh
// Frequency analyzer front end constants
// Tap count, frame length and datapath widths shared by RTL and testbench

`ifndef FAS_MACROS_SVH
`define FAS_MACROS_SVH

//////////////////////////////
// Filter geometry
//////////////////////////////
`define FAS_TAPS       32  // Symmetric low-pass FIR length
`define FAS_FRAME_LEN  16  // Filter outputs per collected frame

//////////////////////////////
// Datapath widths
//////////////////////////////
`define FAS_SAMPLE_W   16  // Signed input and output samples
`define FAS_COEF_W     20  // Signed coefficient word
`define FAS_COEF_FRAC  16  // Fraction bits in each coefficient

// 16x20 product is 36 bits, 32 of them summed need 5 more
// Extra headroom kept on top of that
`define FAS_ACC_W      42

`endif
